//--- Makefile
# Verilator flow for the mesh NoC.

VERILATOR  ?= verilator
TOP        ?= tb_mesh_xy_dual
RTL_TOP    ?= mesh_xy_dual
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 4
FAIL_MSG   ?= Simulation failed
PASS_MSG   ?= Simulation completed successfully
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint lint_rtl clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

lint_rtl:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		verilog/noc_pkg.sv verilog/flit_fifo.sv verilog/router_xy.sv \
		verilog/node_bridge.sv verilog/mesh_xy_dual.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
verilog/noc_pkg.sv
verilog/flit_fifo.sv
verilog/router_xy.sv
verilog/node_bridge.sv
verilog/mesh_xy_dual.sv
tb/tb_mesh_xy_dual.sv

//--- tb/tb_mesh_xy_dual.sv
`default_nettype none

module tb_mesh_xy_dual
    import noc_pkg::*;
();

    localparam int MESH_X    = 3;
    localparam int MESH_Y    = 3;
    localparam int NODES     = MESH_X * MESH_Y;
    localparam int REG_DEPTH = 16;
    localparam int HALF_PER  = 20;
    localparam int DRIVE_DLY = 2;
    localparam int SEED      = 91947;
    localparam int LIMIT     = 20000;

    typedef struct packed {
        logic [3:0] dst;
        op_t        op;
        addr_t      addr;
        data_t      data;
        tag_t       tag;
    } req_t;

    logic                aclk;
    logic                arst_n;
    logic [NODES-1:0]    req_valid;
    logic [NODES-1:0]    req_ready;
    coord_t [NODES-1:0]  req_dst_x;
    coord_t [NODES-1:0]  req_dst_y;
    op_t [NODES-1:0]     req_op;
    addr_t [NODES-1:0]   req_addr;
    data_t [NODES-1:0]   req_data;
    tag_t [NODES-1:0]    req_tag;
    logic [NODES-1:0]    rsp_valid;
    op_t [NODES-1:0]     rsp_op;
    coord_t [NODES-1:0]  rsp_src_x;
    coord_t [NODES-1:0]  rsp_src_y;
    data_t [NODES-1:0]   rsp_data;
    tag_t [NODES-1:0]    rsp_tag;

    // Register files as the clients should see them.
    data_t model_regs [NODES][REG_DEPTH];

    // Requests in flight keyed by source node and tag.
    logic  out_busy [NODES][64];
    req_t  out_req  [NODES][64];
    int    write_cnt [NODES][NODES];
    req_t  pend_q [NODES][$];
    req_t  cur_req [NODES];
    tag_t  next_tag [NODES];
    int    outstanding;
    int    err_count;

    mesh_xy_dual #(
        .MESH_X   (MESH_X),
        .MESH_Y   (MESH_Y),
        .REG_DEPTH(REG_DEPTH)
    ) u_dut (
        .aclk,
        .arst_n,
        .req_valid,
        .req_ready,
        .req_dst_x,
        .req_dst_y,
        .req_op,
        .req_addr,
        .req_data,
        .req_tag,
        .rsp_valid,
        .rsp_op,
        .rsp_src_x,
        .rsp_src_y,
        .rsp_data,
        .rsp_tag
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #HALF_PER aclk = ~aclk;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
        err_count++;
        $display("FAILED time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
        $display("Simulation failed");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic abort_run(string what);
        err_count++;
        $display("ERROR at time %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // A write answers with its own data and a read with the stored word.
    function automatic logic [17:0] model_response(req_t r);
        if (r.op == OP_WRITE) begin
            return {OP_WACK, r.data};
        end else begin
            return {OP_RDATA, model_regs[r.dst][int'(r.addr) % REG_DEPTH]};
        end
    endfunction

    function automatic logic queues_empty();
        for (int n = 0; n < NODES; n++) begin
            if (pend_q[n].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic enqueue(int src, int dst, op_t op, addr_t addr, data_t data);
        req_t r;
        r.dst  = 4'(dst);
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.tag  = '0;
        pend_q[src].push_back(r);
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (!(outstanding == 0 && req_valid == '0 && queues_empty())) begin
            @(posedge aclk);
            cycles++;
            assert (cycles < LIMIT) else abort_run("traffic did not drain before the timeout");
        end
    endtask

    task automatic check_response(int n);
        req_t        r;
        logic [17:0] exp;
        tag_t        t;
        t = rsp_tag[n];
        assert (out_busy[n][t])
            else abort_run($sformatf("node %0d got tag %0d with no request in flight", n, t));
        r   = out_req[n][t];
        exp = model_response(r);
        assert (rsp_src_x[n] == coord_t'(r.dst % MESH_X))
            else mismatch($sformatf("rsp_src_x[%0d]", n), 32'(rsp_src_x[n]), r.dst % MESH_X);
        assert (rsp_src_y[n] == coord_t'(r.dst / MESH_X))
            else mismatch($sformatf("rsp_src_y[%0d]", n), 32'(rsp_src_y[n]), r.dst / MESH_X);
        assert (rsp_op[n] == op_t'(exp[17:16]))
            else mismatch($sformatf("rsp_op[%0d]", n), 32'(rsp_op[n]), 32'(exp[17:16]));
        assert (rsp_data[n] == exp[15:0])
            else mismatch($sformatf("rsp_data[%0d]", n), 32'(rsp_data[n]), 32'(exp[15:0]));
        if (r.op == OP_WRITE) begin
            model_regs[r.dst][int'(r.addr) % REG_DEPTH] = r.data;
            write_cnt[n][r.dst]--;
        end
        out_busy[n][t] = 1'b0;
        outstanding--;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Driver and monitor.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Handshake sampled at negedge and the next request driven after posedge.
    initial begin : driver
        logic [NODES-1:0] taken;
        req_t             r;
        forever begin
            @(negedge aclk);
            taken = req_valid & req_ready;
            for (int n = 0; n < NODES; n++) begin
                if (taken[n]) begin
                    r = cur_req[n];
                    out_busy[n][r.tag] = 1'b1;
                    out_req[n][r.tag]  = r;
                    if (r.op == OP_WRITE) begin
                        write_cnt[n][r.dst]++;
                    end
                    outstanding++;
                    next_tag[n] = next_tag[n] + 6'd1;
                end
            end
            @(posedge aclk);
            #DRIVE_DLY;
            for (int n = 0; n < NODES; n++) begin
                if (taken[n]) begin
                    req_valid[n] = 1'b0;
                end
                if (!req_valid[n] && pend_q[n].size() != 0) begin
                    r = pend_q[n][0];
                    // A read waits until writes to that node are acknowledged.
                    if (!out_busy[n][next_tag[n]] &&
                        (r.op == OP_WRITE || write_cnt[n][r.dst] == 0)) begin
                        r          = pend_q[n].pop_front();
                        r.tag      = next_tag[n];
                        cur_req[n] = r;
                        req_valid[n] = 1'b1;
                        req_dst_x[n] = coord_t'(r.dst % MESH_X);
                        req_dst_y[n] = coord_t'(r.dst / MESH_X);
                        req_op[n]    = r.op;
                        req_addr[n]  = r.addr;
                        req_data[n]  = r.data;
                        req_tag[n]   = r.tag;
                    end
                end
            end
        end
    end

    initial begin : monitor
        forever begin
            @(negedge aclk);
            for (int n = 0; n < NODES; n++) begin
                if (rsp_valid[n]) begin
                    check_response(n);
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : main
        int    dst;
        int    hot;
        addr_t addr;
        data_t data;
        void'($urandom(SEED));
        err_count    = 0;
        outstanding  = 0;
        arst_n    = 1'b0;
        req_valid = '0;
        req_dst_x = '0;
        req_dst_y = '0;
        req_op    = {NODES{OP_WRITE}};
        req_addr  = '0;
        req_data  = '0;
        req_tag   = '0;
        for (int n = 0; n < NODES; n++) begin
            next_tag[n] = '0;
            for (int k = 0; k < REG_DEPTH; k++) begin
                model_regs[n][k] = '0;
            end
            for (int k = 0; k < 64; k++) begin
                out_busy[n][k] = 1'b0;
            end
            for (int k = 0; k < NODES; k++) begin
                write_cnt[n][k] = 0;
            end
        end
        repeat (5) @(posedge aclk);
        #DRIVE_DLY;
        arst_n = 1'b1;

        // Idle mesh.
        @(negedge aclk);
        assert (req_ready == '1)
            else mismatch("req_ready", 32'(req_ready), 32'((1 << NODES) - 1));
        repeat (10) begin
            @(negedge aclk);
            assert (rsp_valid == '0) else mismatch("rsp_valid", 32'(rsp_valid), 32'd0);
        end

        // Fresh register files read as zero.
        for (int n = 0; n < NODES; n++) begin
            for (int a = 0; a < REG_DEPTH; a++) begin
                enqueue(n, (n + 1) % NODES, OP_READ, addr_t'(a), '0);
            end
        end
        wait_drained();

        // Home to home.
        for (int n = 0; n < NODES; n++) begin
            addr = addr_t'($urandom);
            data = data_t'($urandom);
            enqueue(n, n, OP_WRITE, addr, data);
            enqueue(n, n, OP_READ, addr, '0);
        end
        wait_drained();

        // Every pair of nodes with one source at a time.
        for (int s = 0; s < NODES; s++) begin
            for (int d = 0; d < NODES; d++) begin
                if (d != s) begin
                    addr = addr_t'($urandom);
                    data = data_t'($urandom);
                    enqueue(s, d, OP_WRITE, addr, data);
                    enqueue(s, d, OP_READ, addr, '0);
                end
            end
            wait_drained();
        end

        // Random traffic with each source in its own register slot.
        for (int k = 0; k < 12; k++) begin
            for (int s = 0; s < NODES; s++) begin
                dst  = int'($urandom % NODES);
                addr = {4'($urandom), 4'(s)};
                data = data_t'($urandom);
                enqueue(s, dst, OP_WRITE, addr, data);
                if ($urandom % 2 == 0) begin
                    enqueue(s, dst, OP_READ, addr, '0);
                end
            end
        end
        wait_drained();

        // Hotspot.
        hot = int'($urandom % NODES);
        for (int s = 0; s < NODES; s++) begin
            for (int k = 0; k < 8; k++) begin
                enqueue(s, hot, OP_WRITE, addr_t'(s), data_t'($urandom));
            end
            enqueue(s, hot, OP_READ, addr_t'(s), '0);
        end
        wait_drained();

        // No strobe may follow a drained mesh.
        repeat (20) begin
            @(negedge aclk);
            assert (rsp_valid == '0) else mismatch("rsp_valid", 32'(rsp_valid), 32'd0);
        end

        if (err_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "errors were seen");
        end
    end

endmodule

`default_nettype wire

//--- verilog/flit_fifo.sv
`default_nettype none

module flit_fifo #(
    parameter int WIDTH = 40,
    parameter int DEPTH = 4
) (
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;

    function automatic logic [PW-1:0] next_ptr(logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_no_overflow: assert property (@(posedge aclk) disable iff (!arst_n) push |-> !full);
    a_no_underflow: assert property (@(posedge aclk) disable iff (!arst_n) pop |-> !empty);

endmodule

`default_nettype wire

//--- verilog/mesh_xy_dual.sv
`default_nettype none

module mesh_xy_dual
    import noc_pkg::*;
#(
    parameter int  MESH_X     = 3,
    parameter int  MESH_Y     = 3,
    parameter int  FIFO_DEPTH = 4,
    parameter int  REG_DEPTH  = 16,
    localparam int NODES      = MESH_X * MESH_Y
) (
    input  logic                aclk,
    input  logic                arst_n,

    input  logic [NODES-1:0]    req_valid,
    output logic [NODES-1:0]    req_ready,
    input  coord_t [NODES-1:0]  req_dst_x,
    input  coord_t [NODES-1:0]  req_dst_y,
    input  op_t [NODES-1:0]     req_op,
    input  addr_t [NODES-1:0]   req_addr,
    input  data_t [NODES-1:0]   req_data,
    input  tag_t [NODES-1:0]    req_tag,

    output logic [NODES-1:0]    rsp_valid,
    output op_t [NODES-1:0]     rsp_op,
    output coord_t [NODES-1:0]  rsp_src_x,
    output coord_t [NODES-1:0]  rsp_src_y,
    output data_t [NODES-1:0]   rsp_data,
    output tag_t [NODES-1:0]    rsp_tag
);

    localparam int REQ = 0;
    localparam int RSP = 1;

    // Per slot router outputs and input readies, ring slots included.
    logic [NUM_PORTS-1:0]  lk_valid [2][MESH_Y+2][MESH_X+2];
    flit_t [NUM_PORTS-1:0] lk_flit  [2][MESH_Y+2][MESH_X+2];
    logic [NUM_PORTS-1:0]  lk_ready [2][MESH_Y+2][MESH_X+2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Boundary ring.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar n = 0; n < 2; n++) begin : g_net
        for (genvar y = 0; y < MESH_Y + 2; y++) begin : g_ry
            for (genvar x = 0; x < MESH_X + 2; x++) begin : g_rx
                if (y == 0 || y == MESH_Y + 1 || x == 0 || x == MESH_X + 1) begin : g_tie
                    assign lk_valid[n][y][x] = '0;
                    assign lk_flit[n][y][x]  = '0;
                    assign lk_ready[n][y][x] = '1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Nodes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar y = 0; y < MESH_Y; y++) begin : g_y
        for (genvar x = 0; x < MESH_X; x++) begin : g_x
            localparam int ID = y * MESH_X + x;
            localparam int SY = y + 1;
            localparam int SX = x + 1;

            logic  qi_valid;
            flit_t qi_flit;
            logic  qo_ready;
            logic  pi_valid;
            flit_t pi_flit;
            logic  po_ready;

            node_bridge #(
                .NODE_X   (x),
                .NODE_Y   (y),
                .REG_DEPTH(REG_DEPTH)
            ) u_bridge (
                .aclk,
                .arst_n,
                .req_valid(req_valid[ID]),
                .req_ready(req_ready[ID]),
                .req_dst_x(req_dst_x[ID]),
                .req_dst_y(req_dst_y[ID]),
                .req_op   (req_op[ID]),
                .req_addr (req_addr[ID]),
                .req_data (req_data[ID]),
                .req_tag  (req_tag[ID]),
                .rsp_valid(rsp_valid[ID]),
                .rsp_op   (rsp_op[ID]),
                .rsp_src_x(rsp_src_x[ID]),
                .rsp_src_y(rsp_src_y[ID]),
                .rsp_data (rsp_data[ID]),
                .rsp_tag  (rsp_tag[ID]),
                .qi_valid,
                .qi_flit,
                .qi_ready (lk_ready[REQ][SY][SX][DIR_HOME]),
                .qo_valid (lk_valid[REQ][SY][SX][DIR_HOME]),
                .qo_flit  (lk_flit[REQ][SY][SX][DIR_HOME]),
                .qo_ready,
                .pi_valid,
                .pi_flit,
                .pi_ready (lk_ready[RSP][SY][SX][DIR_HOME]),
                .po_valid (lk_valid[RSP][SY][SX][DIR_HOME]),
                .po_flit  (lk_flit[RSP][SY][SX][DIR_HOME]),
                .po_ready
            );

            // Each compass port meets the neighbour's opposite port.
            router_xy #(
                .ROUTER_X  (x),
                .ROUTER_Y  (y),
                .MESH_X    (MESH_X),
                .MESH_Y    (MESH_Y),
                .FIFO_DEPTH(FIFO_DEPTH)
            ) u_req_router (
                .aclk,
                .arst_n,
                .in_valid ({lk_valid[REQ][SY][SX-1][DIR_EAST], lk_valid[REQ][SY+1][SX][DIR_NORTH],
                            lk_valid[REQ][SY][SX+1][DIR_WEST], lk_valid[REQ][SY-1][SX][DIR_SOUTH],
                            qi_valid}),
                .in_flit  ({lk_flit[REQ][SY][SX-1][DIR_EAST], lk_flit[REQ][SY+1][SX][DIR_NORTH],
                            lk_flit[REQ][SY][SX+1][DIR_WEST], lk_flit[REQ][SY-1][SX][DIR_SOUTH],
                            qi_flit}),
                .in_ready (lk_ready[REQ][SY][SX]),
                .out_valid(lk_valid[REQ][SY][SX]),
                .out_flit (lk_flit[REQ][SY][SX]),
                .out_ready({lk_ready[REQ][SY][SX-1][DIR_EAST], lk_ready[REQ][SY+1][SX][DIR_NORTH],
                            lk_ready[REQ][SY][SX+1][DIR_WEST], lk_ready[REQ][SY-1][SX][DIR_SOUTH],
                            qo_ready})
            );

            router_xy #(
                .ROUTER_X  (x),
                .ROUTER_Y  (y),
                .MESH_X    (MESH_X),
                .MESH_Y    (MESH_Y),
                .FIFO_DEPTH(FIFO_DEPTH)
            ) u_rsp_router (
                .aclk,
                .arst_n,
                .in_valid ({lk_valid[RSP][SY][SX-1][DIR_EAST], lk_valid[RSP][SY+1][SX][DIR_NORTH],
                            lk_valid[RSP][SY][SX+1][DIR_WEST], lk_valid[RSP][SY-1][SX][DIR_SOUTH],
                            pi_valid}),
                .in_flit  ({lk_flit[RSP][SY][SX-1][DIR_EAST], lk_flit[RSP][SY+1][SX][DIR_NORTH],
                            lk_flit[RSP][SY][SX+1][DIR_WEST], lk_flit[RSP][SY-1][SX][DIR_SOUTH],
                            pi_flit}),
                .in_ready (lk_ready[RSP][SY][SX]),
                .out_valid(lk_valid[RSP][SY][SX]),
                .out_flit (lk_flit[RSP][SY][SX]),
                .out_ready({lk_ready[RSP][SY][SX-1][DIR_EAST], lk_ready[RSP][SY+1][SX][DIR_NORTH],
                            lk_ready[RSP][SY][SX+1][DIR_WEST], lk_ready[RSP][SY-1][SX][DIR_SOUTH],
                            po_ready})
            );
        end
    end

endmodule

`default_nettype wire

//--- verilog/noc_pkg.sv
`default_nettype none

package noc_pkg;

    typedef logic [1:0]  coord_t;
    typedef logic [7:0]  addr_t;
    typedef logic [15:0] data_t;
    typedef logic [5:0]  tag_t;

    // Flit layout, MSB first: dst x, dst y, src x, src y, op, addr, data, tag.
    typedef logic [39:0] flit_t;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_WACK,
        OP_RDATA
    } op_t;

    typedef enum logic [2:0] {
        DIR_HOME,
        DIR_NORTH,
        DIR_EAST,
        DIR_SOUTH,
        DIR_WEST
    } dir_t;

    localparam int NUM_PORTS = 5;

    function automatic flit_t flit_pack(coord_t dst_x, coord_t dst_y, coord_t src_x,
                                        coord_t src_y, op_t op, addr_t addr,
                                        data_t data, tag_t tag);
        return {dst_x, dst_y, src_x, src_y, op, addr, data, tag};
    endfunction

    function automatic coord_t flit_dst_x(flit_t f);
        return f[39:38];
    endfunction

    function automatic coord_t flit_dst_y(flit_t f);
        return f[37:36];
    endfunction

    function automatic coord_t flit_src_x(flit_t f);
        return f[35:34];
    endfunction

    function automatic coord_t flit_src_y(flit_t f);
        return f[33:32];
    endfunction

    function automatic op_t flit_op(flit_t f);
        return op_t'(f[31:30]);
    endfunction

    function automatic addr_t flit_addr(flit_t f);
        return f[29:22];
    endfunction

    function automatic data_t flit_data(flit_t f);
        return f[21:6];
    endfunction

    function automatic tag_t flit_tag(flit_t f);
        return f[5:0];
    endfunction

endpackage

`default_nettype wire

//--- verilog/node_bridge.sv
`default_nettype none

module node_bridge
    import noc_pkg::*;
#(
    parameter int NODE_X    = 0,
    parameter int NODE_Y    = 0,
    parameter int REG_DEPTH = 16
) (
    input  logic   aclk,
    input  logic   arst_n,

    input  logic   req_valid,
    output logic   req_ready,
    input  coord_t req_dst_x,
    input  coord_t req_dst_y,
    input  op_t    req_op,
    input  addr_t  req_addr,
    input  data_t  req_data,
    input  tag_t   req_tag,

    output logic   rsp_valid,
    output op_t    rsp_op,
    output coord_t rsp_src_x,
    output coord_t rsp_src_y,
    output data_t  rsp_data,
    output tag_t   rsp_tag,

    output logic   qi_valid,
    output flit_t  qi_flit,
    input  logic   qi_ready,
    input  logic   qo_valid,
    input  flit_t  qo_flit,
    output logic   qo_ready,

    output logic   pi_valid,
    output flit_t  pi_flit,
    input  logic   pi_ready,
    input  logic   po_valid,
    input  flit_t  po_flit,
    output logic   po_ready
);

    localparam coord_t MY_X = coord_t'(NODE_X);
    localparam coord_t MY_Y = coord_t'(NODE_Y);
    localparam int     AW   = (REG_DEPTH > 1) ? $clog2(REG_DEPTH) : 1;

    logic          inj_valid;
    flit_t         inj_flit;
    logic          out_full;
    flit_t         out_flit;
    logic          dlv_valid;
    flit_t         dlv_flit;
    data_t         regs [REG_DEPTH];
    logic          serve;
    logic          is_write;
    addr_t         srv_addr;
    logic [AW-1:0] reg_idx;
    op_t           srv_op;
    data_t         srv_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Injection of local requests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req_ready = !inj_valid;
    assign qi_valid  = inj_valid;
    assign qi_flit   = inj_flit;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            inj_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            inj_valid <= 1'b1;
        end else if (qi_ready) begin
            inj_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid && req_ready) begin
            inj_flit <= flit_pack(req_dst_x, req_dst_y, MY_X, MY_Y,
                                  req_op, req_addr, req_data, req_tag);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serving remote requests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Held response blocks the request network.
    assign qo_ready = !out_full;
    assign serve    = qo_valid && qo_ready;
    assign is_write = (flit_op(qo_flit) == OP_WRITE);
    assign srv_addr = flit_addr(qo_flit);
    assign reg_idx  = srv_addr[AW-1:0];
    assign srv_op   = is_write ? OP_WACK : OP_RDATA;
    assign srv_data = is_write ? flit_data(qo_flit) : regs[reg_idx];
    assign pi_valid = out_full;
    assign pi_flit  = out_flit;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (serve && is_write) begin
            regs[reg_idx] <= flit_data(qo_flit);
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_full <= 1'b0;
        end else if (serve) begin
            out_full <= 1'b1;
        end else if (pi_ready) begin
            out_full <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (serve) begin
            out_flit <= flit_pack(flit_src_x(qo_flit), flit_src_y(qo_flit), MY_X, MY_Y,
                                  srv_op, srv_addr, srv_data, flit_tag(qo_flit));
        end
    end

    // Response delivery, one-cycle strobe.
    assign po_ready = 1'b1;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            dlv_valid <= 1'b0;
        end else begin
            dlv_valid <= po_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (po_valid) begin
            dlv_flit <= po_flit;
        end
    end

    assign rsp_valid = dlv_valid;
    assign rsp_op    = flit_op(dlv_flit);
    assign rsp_src_x = flit_src_x(dlv_flit);
    assign rsp_src_y = flit_src_y(dlv_flit);
    assign rsp_data  = flit_data(dlv_flit);
    assign rsp_tag   = flit_tag(dlv_flit);

    a_req_here: assert property (@(posedge aclk) disable iff (!arst_n)
        qo_valid |-> flit_dst_x(qo_flit) == MY_X && flit_dst_y(qo_flit) == MY_Y);
    a_rsp_here: assert property (@(posedge aclk) disable iff (!arst_n)
        po_valid |-> flit_dst_x(po_flit) == MY_X && flit_dst_y(po_flit) == MY_Y);

endmodule

`default_nettype wire

//--- verilog/router_xy.sv
`default_nettype none

module router_xy
    import noc_pkg::*;
#(
    parameter int ROUTER_X   = 0,
    parameter int ROUTER_Y   = 0,
    parameter int MESH_X     = 3,
    parameter int MESH_Y     = 3,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  logic [NUM_PORTS-1:0]  in_valid,
    input  flit_t [NUM_PORTS-1:0] in_flit,
    output logic [NUM_PORTS-1:0]  in_ready,
    output logic [NUM_PORTS-1:0]  out_valid,
    output flit_t [NUM_PORTS-1:0] out_flit,
    input  logic [NUM_PORTS-1:0]  out_ready
);

    localparam coord_t MY_X = coord_t'(ROUTER_X);
    localparam coord_t MY_Y = coord_t'(ROUTER_Y);

    // Ports that have a neighbour, bit order WEST SOUTH EAST NORTH HOME.
    localparam logic [NUM_PORTS-1:0] PORT_EN = {
        ROUTER_X != 0,
        ROUTER_Y != MESH_Y - 1,
        ROUTER_X != MESH_X - 1,
        ROUTER_Y != 0,
        1'b1
    };

    flit_t [NUM_PORTS-1:0]      head;
    logic [NUM_PORTS-1:0]       empty;
    logic [NUM_PORTS-1:0]       full;
    logic [NUM_PORTS-1:0]       pop;
    dir_t                       route [NUM_PORTS];
    logic [NUM_PORTS-1:0]       gnt_valid;
    logic [NUM_PORTS-1:0][2:0]  gnt_idx;
    logic [NUM_PORTS-1:0][2:0]  rr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input buffers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        flit_fifo #(
            .WIDTH($bits(flit_t)),
            .DEPTH(FIFO_DEPTH)
        ) u_fifo (
            .aclk,
            .arst_n,
            .push     (in_valid[i] & PORT_EN[i] & ~full[i]),
            .push_data(in_flit[i]),
            .pop      (pop[i]),
            .head     (head[i]),
            .empty    (empty[i]),
            .full     (full[i])
        );
    end

    assign in_ready = ~full;

    // X first, then Y.
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (flit_dst_x(head[i]) > MY_X) begin
                route[i] = DIR_EAST;
            end else if (flit_dst_x(head[i]) < MY_X) begin
                route[i] = DIR_WEST;
            end else if (flit_dst_y(head[i]) > MY_Y) begin
                route[i] = DIR_SOUTH;
            end else if (flit_dst_y(head[i]) < MY_Y) begin
                route[i] = DIR_NORTH;
            end else begin
                route[i] = DIR_HOME;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output arbitration.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Scan from the lowest priority up so the last hit wins.
    always_comb begin
        int idx;
        for (int o = 0; o < NUM_PORTS; o++) begin
            gnt_valid[o] = 1'b0;
            gnt_idx[o]   = '0;
            for (int k = NUM_PORTS - 1; k >= 0; k--) begin
                idx = int'(rr[o]) + k;
                if (idx >= NUM_PORTS) begin
                    idx = idx - NUM_PORTS;
                end
                if (!empty[idx] && route[idx] == dir_t'(o)) begin
                    gnt_valid[o] = 1'b1;
                    gnt_idx[o]   = 3'(idx);
                end
            end
        end
    end

    always_comb begin
        pop = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_flit[o] = head[gnt_idx[o]];
            if (gnt_valid[o] && out_ready[o]) begin
                pop[gnt_idx[o]] = 1'b1;
            end
        end
    end

    assign out_valid = gnt_valid;

    // A stalled winner keeps top priority, so its grant holds.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rr <= '0;
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (gnt_valid[o] && out_ready[o]) begin
                    rr[o] <= (gnt_idx[o] == 3'(NUM_PORTS - 1)) ? 3'd0 : gnt_idx[o] + 3'd1;
                end else if (gnt_valid[o]) begin
                    rr[o] <= gnt_idx[o];
                end
            end
        end
    end

    a_no_edge_out: assert property (@(posedge aclk) disable iff (!arst_n)
        (out_valid & ~PORT_EN) == '0);

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_chk
        a_hold: assert property (@(posedge aclk) disable iff (!arst_n)
            out_valid[o] && !out_ready[o] |=> out_valid[o] && $stable(out_flit[o]));
    end

endmodule

`default_nettype wire
